// File: common/memCtrlPkg.sv
`include "memCtrl_cfg.svh"

package memCtrlPkg;

    // byte count of one access, only 1, 2 and 4 are legal
    typedef logic [2:0] accessLen_t;

    // a fetch always reads a full word
    localparam accessLen_t lenWord = accessLen_t'(`MC_WORD_BYTES);

    // one transaction as handed from a client to the sequencer
    typedef struct packed {
        logic [`MC_ADDR_W-1:0] addr;
        // store data, low byte goes to addr
        logic [`MC_WORD_W-1:0] wdata;
        accessLen_t            len;
        logic                  write;
    } memReq_t;

    // sequencer result, data is zero-extended
    typedef struct packed {
        logic                  done;
        logic [`MC_WORD_W-1:0] data;
    } memRsp_t;

endpackage

// File: common/memCtrl_cfg.svh
`ifndef MEMCTRL_CFG_SVH
`define MEMCTRL_CFG_SVH

// byte address on both client ports and the RAM port
`define MC_ADDR_W 32

// instruction and data word
`define MC_WORD_W 32

// RAM data port
`define MC_BYTE_W 8

// bytes in one word, also the longest access
`define MC_WORD_BYTES 4

`endif

// File: filelist.f
+incdir+common
common/memCtrlPkg.sv
src/memArbiter.sv
memAccess/byteSequencer.sv
src/memCtrlTop.sv
sim/ramModel.sv
sim/tb_memCtrl.sv

// File: memAccess/byteSequencer.sv
`timescale 1ns/1ps
`include "memCtrl_cfg.svh"

module byteSequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_active,

    input  logic                  i_start,
    input  memCtrlPkg::memReq_t   i_req,
    output memCtrlPkg::memRsp_t   o_rsp,

    input  logic [`MC_BYTE_W-1:0] i_memRdata,
    output logic [`MC_ADDR_W-1:0] o_memAddr,
    output logic                  o_memWe,
    output logic [`MC_BYTE_W-1:0] o_memWdata
);
    localparam int LaneW = $clog2(`MC_WORD_BYTES);
    localparam int CntW  = $bits(memCtrlPkg::accessLen_t);

    // control state
    logic                   busy;
    logic                   isWrite;
    memCtrlPkg::accessLen_t len;
    memCtrlPkg::accessLen_t issueCnt;
    memCtrlPkg::accessLen_t capCnt;
    logic                   lastActive;
    logic                   doneReg;

    // transaction payload
    logic [`MC_ADDR_W-1:0]                     baseAddr;
    logic [`MC_WORD_BYTES-1:0][`MC_BYTE_W-1:0] wrBytes;
    logic [`MC_WORD_BYTES-1:0][`MC_BYTE_W-1:0] rdBytes;

    logic                   capOk;
    memCtrlPkg::accessLen_t issIdx;
    logic [LaneW-1:0]       issLane;
    logic [LaneW-1:0]       capLane;
    logic [`MC_ADDR_W-1:0]  addrOfs;
    logic                   issueOk;
    logic                   lastWrite;
    logic                   lastCapture;

    // byte capCnt was issued last cycle and RAM shows it now
    assign capOk = busy && !isWrite && lastActive && (issueCnt != capCnt);

    // after a stall the outstanding read byte is lost, so issue it again
    assign issIdx = (isWrite || capOk) ? issueCnt : capCnt;

    assign issueOk = busy && (issIdx < len);

    assign lastWrite   = issueOk && isWrite && (issIdx == len - 3'd1);
    assign lastCapture = capOk && (capCnt == len - 3'd1);

    assign issLane = issIdx[LaneW-1:0];
    assign capLane = capCnt[LaneW-1:0];
    assign addrOfs = {{(`MC_ADDR_W - CntW){1'b0}}, issIdx};

    // RAM port
    assign o_memAddr  = busy ? baseAddr + addrOfs : '0;
    assign o_memWe    = i_active && issueOk && isWrite;
    assign o_memWdata = wrBytes[issLane];

    assign o_rsp.done = doneReg;
    assign o_rsp.data = rdBytes;

    // tells whether the byte on i_memRdata was sampled in an active cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            lastActive <= 1'b0;
        end else begin
            lastActive <= i_active;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            isWrite  <= 1'b0;
            len      <= '0;
            issueCnt <= '0;
            capCnt   <= '0;
            doneReg  <= 1'b0;
        end else if (i_active) begin
            // done stays up through stalls and drops after one active cycle
            doneReg <= 1'b0;
            if (i_start) begin
                busy     <= 1'b1;
                isWrite  <= i_req.write;
                len      <= i_req.len;
                issueCnt <= '0;
                capCnt   <= '0;
            end else if (busy) begin
                if (issueOk) begin
                    issueCnt <= issIdx + 3'd1;
                end
                if (capOk) begin
                    capCnt <= capCnt + 3'd1;
                end
                if (lastWrite || lastCapture) begin
                    busy     <= 1'b0;
                    doneReg  <= 1'b1;
                    issueCnt <= '0;
                    capCnt   <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_active) begin
            if (i_start) begin
                baseAddr <= i_req.addr;
                wrBytes  <= i_req.wdata;
                // upper lanes of a short load stay zero
                rdBytes  <= '0;
            end else if (capOk) begin
                rdBytes[capLane] <= i_memRdata;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the memory controller testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

TOP=tb_memCtrl
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 --top-module "$TOP" -Mdir "$OBJ_DIR" -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "simulation reported errors, see $LOG"
    exit 1
fi

echo "simulation finished without errors"
exit 0

// File: sim/ramModel.sv
`timescale 1ns/1ps
`include "memCtrl_cfg.svh"

module ramModel #(
    parameter int Depth = 512
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`MC_ADDR_W-1:0] i_addr,
    input  logic                  i_we,
    input  logic [`MC_BYTE_W-1:0] i_wdata,
    output logic [`MC_BYTE_W-1:0] o_rdata,
    output int                    o_wrCount
);
    localparam int IdxW = $clog2(Depth);

    logic [`MC_BYTE_W-1:0] mem [Depth];
    logic [IdxW-1:0]       idx;

    // fill byte mixes low and high index bits
    function automatic logic [`MC_BYTE_W-1:0] fillByte(int a);
        logic [15:0] v;
        v = 16'(a) * 16'd37;
        fillByte = v[7:0] ^ v[15:8];
    endfunction

    // model wraps addresses inside its depth
    assign idx = i_addr[IdxW-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < Depth; i++) begin
                mem[i] <= fillByte(i);
            end
            o_rdata   <= '0;
            o_wrCount <= 0;
        end else begin
            if (i_we) begin
                mem[idx]  <= i_wdata;
                o_wrCount <= o_wrCount + 1;
            end
            // one-cycle read latency, old byte on a write
            o_rdata <= mem[idx];
        end
    end

endmodule

// File: sim/tb_memCtrl.sv
`timescale 1ns/1ps
`include "memCtrl_cfg.svh"

module tb_memCtrl;
    localparam int Period  = 40;
    localparam int NumOps  = 300;
    localparam int RamSize = 512;

    logic                  clk;
    logic                  rst;
    logic                  rdy;
    logic                  ioFull;
    logic                  dcEn;
    memCtrlPkg::memReq_t   dcReq;
    logic                  dcDone;
    logic [`MC_WORD_W-1:0] dcData;
    logic                  ifEn;
    logic [`MC_ADDR_W-1:0] ifAddr;
    logic                  ifDone;
    logic [`MC_WORD_W-1:0] ifInst;
    logic [`MC_BYTE_W-1:0] memRdata;
    logic [`MC_ADDR_W-1:0] memAddr;
    logic                  memWe;
    logic [`MC_BYTE_W-1:0] memWdata;
    int                    wrCount;

    // stimulus and reference state
    integer                seed;
    int                    errCount;
    int                    checkCount;
    int                    expWrites;
    logic [7:0]            refMem [RamSize];
    memCtrlPkg::memReq_t   nextReq;
    logic [31:0]           nextIfAddr;
    logic                  dcPending;
    logic                  dcWrite;
    logic                  ifPending;
    logic [31:0]           dcExp;
    logic [31:0]           ifExp;
    logic                  stallNow;
    logic                  opStalled;
    int                    opCycle;
    int                    dcDoneAt;
    int                    ifDoneAt;
    logic                  lastDcDone;
    logic                  lastIfDone;

    memCtrlTop DUT (
        .clk        (clk),
        .rst        (rst),
        .i_rdy      (rdy),
        .i_ioFull   (ioFull),
        .i_dcEn     (dcEn),
        .i_dcReq    (dcReq),
        .o_dcDone   (dcDone),
        .o_dcData   (dcData),
        .i_ifEn     (ifEn),
        .i_ifAddr   (ifAddr),
        .o_ifDone   (ifDone),
        .o_ifInst   (ifInst),
        .i_memRdata (memRdata),
        .o_memAddr  (memAddr),
        .o_memWe    (memWe),
        .o_memWdata (memWdata)
    );

    ramModel #(.Depth(RamSize)) ram (
        .clk       (clk),
        .rst       (rst),
        .i_addr    (memAddr),
        .i_we      (memWe),
        .i_wdata   (memWdata),
        .o_rdata   (memRdata),
        .o_wrCount (wrCount)
    );

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    // budget of 20 cycles for each operation
    initial begin
        #(NumOps * 20 * Period);
        $display("timeout: test did not finish within %0d ns", NumOps * 20 * Period);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [31:0] nextRand();
        nextRand = $random(seed);
    endfunction

    // zero-extended little-endian read of the reference bytes
    function automatic logic [31:0] loadFromModel(logic [31:0] addr, int len);
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < len; k++) begin
            w[8*k +: 8] = refMem[9'(addr + k)];
        end
        return w;
    endfunction

    task automatic storeToModel(logic [31:0] addr, logic [31:0] data, int len);
        for (int k = 0; k < len; k++) begin
            refMem[9'(addr + k)] = data[8*k +: 8];
        end
    endtask

    task automatic reportFailure(string what);
        errCount++;
        $display("%s at %0d ns", what, $time);
    endtask

    task automatic compareValue(string name, logic [31:0] got, logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("FAILED %s: got %h, expected %h at %0d ns", name, got, exp, $time);
        end
    endtask

    task automatic checkOutputs();
        if (dcDone && lastDcDone) begin
            reportFailure("data done held for more than one cycle");
        end
        if (ifDone && lastIfDone) begin
            reportFailure("fetch done held for more than one cycle");
        end
        lastDcDone = dcDone;
        lastIfDone = ifDone;
        if (stallNow && memWe) begin
            reportFailure("write strobe high in a stall cycle");
        end
        if (stallNow && (dcDone || ifDone)) begin
            reportFailure("done pulse in a stall cycle");
        end
        if (memWe) begin
            if (!(dcPending && dcWrite)) begin
                reportFailure("write strobe without a pending store");
            end else if (memAddr - nextReq.addr >= 32'(nextReq.len)) begin
                reportFailure("store wrote a byte outside its range");
            end else begin
                compareValue("o_memWdata", {24'h0, memWdata}, {24'h0, refMem[9'(memAddr)]});
            end
        end
        if (ifDone) begin
            if (!ifPending) begin
                reportFailure("fetch done without a pending request");
            end else begin
                if (dcPending) begin
                    reportFailure("fetch finished before the data access");
                end
                compareValue("o_ifInst", ifInst, ifExp);
                ifPending = 1'b0;
                ifDoneAt  = opCycle;
            end
        end
        if (dcDone) begin
            if (!dcPending) begin
                reportFailure("data done without a pending request");
            end else begin
                if (!dcWrite) begin
                    compareValue("o_dcData", dcData, dcExp);
                end
                dcPending = 1'b0;
                dcDoneAt  = opCycle;
            end
        end
    endtask

    // drive at the falling edge, look at outputs a quarter period later
    task automatic stepCycle();
        logic [31:0] r;
        @(negedge clk);
        r = nextRand();
        // about one cycle in eight is a stall
        stallNow  = (r[2:0] == 3'd0);
        rdy       = !(stallNow && r[3]);
        ioFull    = stallNow && !r[3];
        dcEn      = dcPending;
        dcReq     = nextReq;
        ifEn      = ifPending;
        ifAddr    = nextIfAddr;
        opStalled = opStalled || stallNow;
        #(Period / 4);
        checkOutputs();
        opCycle++;
    endtask

    task automatic runOperation();
        logic [31:0] r;
        logic [1:0]  kind;
        int          len;
        int          expAt;
        int          doneAt;
        r    = nextRand();
        // 0 fetch, 1 load, 2 store, 3 data and fetch together
        kind = r[1:0];
        len  = (r[3:2] == 2'd0) ? 1 : ((r[3:2] == 2'd1) ? 2 : 4);
        dcPending = (kind != 2'd0);
        ifPending = (kind == 2'd0) || (kind == 2'd3);
        dcWrite   = (kind == 2'd2) || ((kind == 2'd3) && r[4]);
        nextReq.addr  = {24'h0, r[15:8]};
        nextReq.wdata = nextRand();
        nextReq.len   = 3'(len);
        nextReq.write = dcWrite;
        nextIfAddr    = {24'h0, r[23:16]};
        if (dcPending && dcWrite) begin
            storeToModel(nextReq.addr, nextReq.wdata, len);
            expWrites += len;
        end else if (dcPending) begin
            dcExp = loadFromModel(nextReq.addr, len);
        end
        // data goes first, so a fetch sees the finished store
        ifExp     = loadFromModel(nextIfAddr, 4);
        opCycle   = 0;
        opStalled = 1'b0;
        dcDoneAt  = -1;
        ifDoneAt  = -1;
        while (dcPending || ifPending) begin
            stepCycle();
        end
        if (!opStalled && kind != 2'd3) begin
            // acceptance edge, then n edges for a write and n+1 for a read
            if (kind == 2'd0) begin
                expAt  = 6;
                doneAt = ifDoneAt;
            end else begin
                expAt  = dcWrite ? len + 1 : len + 2;
                doneAt = dcDoneAt;
            end
            checkCount++;
            if (doneAt != expAt) begin
                reportFailure($sformatf("done came %0d cycles after the request, not %0d",
                                        doneAt, expAt));
            end
        end
    endtask

    initial begin
        seed       = 32'h58ae0fd5;
        errCount   = 0;
        checkCount = 0;
        expWrites  = 0;
        rst        = 1'b1;
        rdy        = 1'b1;
        ioFull     = 1'b0;
        dcEn       = 1'b0;
        dcReq      = '0;
        ifEn       = 1'b0;
        ifAddr     = '0;
        nextReq    = '0;
        nextIfAddr = '0;
        dcPending  = 1'b0;
        dcWrite    = 1'b0;
        ifPending  = 1'b0;
        dcExp      = '0;
        ifExp      = '0;
        stallNow   = 1'b0;
        opStalled  = 1'b0;
        opCycle    = 0;
        dcDoneAt   = -1;
        ifDoneAt   = -1;
        lastDcDone = 1'b0;
        lastIfDone = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // RAM model filled itself during reset
        for (int i = 0; i < RamSize; i++) begin
            refMem[i] = ram.mem[i];
        end

        // quiet bus before any request
        repeat (4) begin
            stepCycle();
            compareValue("o_memAddr", memAddr, '0);
        end

        repeat (NumOps) begin
            runOperation();
        end

        for (int i = 0; i < RamSize; i++) begin
            compareValue($sformatf("ram.mem[%0h]", i), {24'h0, ram.mem[i]}, {24'h0, refMem[i]});
        end
        compareValue("write count", wrCount, expWrites);

        $display("%0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: src/memArbiter.sv
`timescale 1ns/1ps
`include "memCtrl_cfg.svh"

module memArbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_active,

    input  logic                  i_dcEn,
    input  memCtrlPkg::memReq_t   i_dcReq,
    input  logic                  i_ifEn,
    input  logic [`MC_ADDR_W-1:0] i_ifAddr,

    input  memCtrlPkg::memRsp_t   i_seqRsp,
    output logic                  o_seqStart,
    output memCtrlPkg::memReq_t   o_seqReq,

    output logic                  o_dcDone,
    output logic [`MC_WORD_W-1:0] o_dcData,
    output logic                  o_ifDone,
    output logic [`MC_WORD_W-1:0] o_ifInst
);
    typedef enum logic [1:0] {
        srcIdle,
        srcData,
        srcFetch
    } grantSrc_t;

    grantSrc_t           grant;
    memCtrlPkg::memReq_t fetchReq;
    logic                finish;

    // fetch is always a full-word read
    always_comb begin
        fetchReq.addr  = i_ifAddr;
        fetchReq.wdata = '0;
        fetchReq.len   = memCtrlPkg::lenWord;
        fetchReq.write = 1'b0;
    end

    // data client wins when both ask in the same cycle
    assign o_seqStart = i_active && (grant == srcIdle) && (i_dcEn || i_ifEn);
    assign o_seqReq   = i_dcEn ? i_dcReq : fetchReq;

    // done only counts in an active cycle, so a stall delays the pulse
    assign finish = i_active && i_seqRsp.done;

    assign o_dcDone = finish && (grant == srcData);
    assign o_ifDone = finish && (grant == srcFetch);

    assign o_dcData = (grant == srcData) ? i_seqRsp.data : '0;
    assign o_ifInst = (grant == srcFetch) ? i_seqRsp.data : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= srcIdle;
        end else if (i_active) begin
            case (grant)
                srcIdle: begin
                    if (i_dcEn) begin
                        grant <= srcData;
                    end else if (i_ifEn) begin
                        grant <= srcFetch;
                    end
                end
                default: begin
                    // bus is held until the sequencer reports done
                    if (i_seqRsp.done) begin
                        grant <= srcIdle;
                    end
                end
            endcase
        end
    end

endmodule

// File: src/memCtrlTop.sv
`timescale 1ns/1ps
`include "memCtrl_cfg.svh"

module memCtrlTop (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_rdy,
    input  logic                  i_ioFull,

    // data client
    input  logic                  i_dcEn,
    input  memCtrlPkg::memReq_t   i_dcReq,
    output logic                  o_dcDone,
    output logic [`MC_WORD_W-1:0] o_dcData,

    // fetch client
    input  logic                  i_ifEn,
    input  logic [`MC_ADDR_W-1:0] i_ifAddr,
    output logic                  o_ifDone,
    output logic [`MC_WORD_W-1:0] o_ifInst,

    // byte RAM
    input  logic [`MC_BYTE_W-1:0] i_memRdata,
    output logic [`MC_ADDR_W-1:0] o_memAddr,
    output logic                  o_memWe,
    output logic [`MC_BYTE_W-1:0] o_memWdata
);
    logic                active;
    logic                seqStart;
    memCtrlPkg::memReq_t seqReq;
    memCtrlPkg::memRsp_t seqRsp;

    // whole controller freezes on not ready or full I/O buffer
    assign active = i_rdy && !i_ioFull;

    memArbiter arbiter (
        .clk        (clk),
        .rst        (rst),
        .i_active   (active),
        .i_dcEn     (i_dcEn),
        .i_dcReq    (i_dcReq),
        .i_ifEn     (i_ifEn),
        .i_ifAddr   (i_ifAddr),
        .i_seqRsp   (seqRsp),
        .o_seqStart (seqStart),
        .o_seqReq   (seqReq),
        .o_dcDone   (o_dcDone),
        .o_dcData   (o_dcData),
        .o_ifDone   (o_ifDone),
        .o_ifInst   (o_ifInst)
    );

    byteSequencer sequencer (
        .clk        (clk),
        .rst        (rst),
        .i_active   (active),
        .i_start    (seqStart),
        .i_req      (seqReq),
        .o_rsp      (seqRsp),
        .i_memRdata (i_memRdata),
        .o_memAddr  (o_memAddr),
        .o_memWe    (o_memWe),
        .o_memWdata (o_memWdata)
    );

endmodule
